// ==== include/memory_config.svh ====
`ifndef MEMORY_CONFIG_SVH
`define MEMORY_CONFIG_SVH

// RAM size in words, as an address width
// 10 bits gives 1024 words, 4 KiB
`define MEM_WORD_ADDR_WIDTH 10

// Peers sharing the data port
// Peer 0 is the core load/store port
// Peer 1 is the AXI4-Lite host port
`define MEM_PEER_COUNT 2

// Byte address adds the two offset bits
// plus the MMIO select on top
// so it is MEM_WORD_ADDR_WIDTH + 3 wide
// and MMIO is its most significant bit

`endif

// ==== logic/MemoryTypes.sv ====
`default_nettype none

`include "memory_config.svh"

package MemoryTypes;
	typedef logic [31:0] Word_t;
	typedef logic [`MEM_WORD_ADDR_WIDTH-1:0] WordAddress_t;

	// MMIO select, word address, byte offset
	typedef logic [`MEM_WORD_ADDR_WIDTH+2:0] ByteAddress_t;

	typedef logic [2:0] Funct3_t;  // RISC-V load/store width code

	typedef struct packed
	{
		logic write;  // Store when set
		Funct3_t funct3;
		ByteAddress_t address;
		Word_t data;  // Store data, ignored on loads
	} MemRequest_t;

	typedef struct packed
	{
		Word_t data;  // Extended load value
		logic fault;  // MMIO, misaligned or bad funct3
	} MemResponse_t;

	// Read-modify-write sequencer
	typedef enum logic [1:0]
	{
		IDLE,
		PRELOAD,  // Old word being read
		FINISH  // Response cycle
	} WrapperState_t;

	// Host transaction handler
	typedef enum logic [1:0]
	{
		AXI_IDLE,
		AXI_ISSUE,
		AXI_WAIT,
		AXI_RESPOND
	} AxiSlaveState_t;
endpackage

`default_nettype wire

// ==== logic/InferredRAM.sv ====
`timescale 1ns/1ps
`default_nettype none

module InferredRAM
(
	input logic clock,
	input logic writeEnable,
	input MemoryTypes::WordAddress_t writeAddress,
	input MemoryTypes::WordAddress_t readAddressA,
	input MemoryTypes::WordAddress_t readAddressB,
	input MemoryTypes::Word_t dataIn,
	output MemoryTypes::Word_t dataOutA,
	output MemoryTypes::Word_t dataOutB
);
	import MemoryTypes::*;

	localparam int DEPTH = 2 ** $bits(WordAddress_t);

	Word_t memory [DEPTH];  // Lowest-addressed byte in bits 31:24

	// Memory starts out cleared
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
			memory[i] = '0;
	end

	always_ff @(posedge clock)
	begin
		if (writeEnable)
			memory[writeAddress] <= dataIn;

		// Both ports read the old word on a collision
		dataOutA <= memory[readAddressA];
		dataOutB <= memory[readAddressB];  // Instruction fetch
	end
endmodule: InferredRAM

`default_nettype wire

// ==== logic/RAMWrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module RAMWrapper
(
	input logic clock,
	input logic reset,
	input logic opValid,
	input MemoryTypes::MemRequest_t op,
	output logic opReady,
	output logic opDone,
	output MemoryTypes::MemResponse_t response,
	input MemoryTypes::WordAddress_t fetchAddress,
	output MemoryTypes::Word_t instruction
);
	import MemoryTypes::*;

	localparam int MMIO_BIT = $bits(ByteAddress_t) - 1;

	WrapperState_t state;
	MemRequest_t heldOp;  // Request being worked on
	logic heldFault;
	logic accept;
	logic fault;
	logic badWidth;  // Misaligned or illegal code
	logic writeEnable;
	WordAddress_t ramAddress;
	Word_t ramDataIn;
	Word_t ramDataOut;  // RAM byte order
	Word_t rawInstruction;
	Word_t loadValue;
	logic [7:0] byteLane;
	logic [15:0] halfLane;

	// RAM order to bus order and back
	function automatic Word_t swapBytes32(input Word_t word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	function automatic logic [15:0] swapBytes16(input logic [15:0] half);
		return {half[7:0], half[15:8]};
	endfunction

	// Offset 0 sits in the top lane
	function automatic logic [7:0] byteAtOffset(input Word_t word, input logic [1:0] offset);
		return word[(3 - offset) * 8 +: 8];
	endfunction

	function automatic logic [15:0] halfwordAtOffset(input Word_t word, input logic [1:0] offset);
		return offset[1] ? word[15:0] : word[31:16];
	endfunction

	function automatic Word_t withByteAtOffset(input Word_t word, input logic [7:0] value,
		input logic [1:0] offset);
		Word_t merged;
		merged = word;
		merged[(3 - offset) * 8 +: 8] = value;
		return merged;
	endfunction

	function automatic Word_t withHalfwordAtOffset(input Word_t word, input logic [15:0] value,
		input logic [1:0] offset);
		return offset[1] ? {word[31:16], value} : {value, word[15:0]};
	endfunction

	assign opReady = state == IDLE;
	assign opDone = state == FINISH;
	assign accept = opValid && opReady;

	// Alignment and legality of the incoming request
	always_comb
	begin
		case (op.funct3)
			3'b000: badWidth = 1'b0;  // lb/sb
			3'b001: badWidth = op.address[0];  // lh/sh
			3'b010: badWidth = |op.address[1:0];  // lw/sw
			3'b100: badWidth = op.write;  // lbu, no store form
			3'b101: badWidth = op.write | op.address[0];  // lhu
			default: badWidth = 1'b1;
		endcase
		fault = op.address[MMIO_BIT] | badWidth;  // No MMIO devices
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
					if (accept)
						state <= (op.write && op.funct3 != 3'b010 && !fault) ? PRELOAD : FINISH;
				PRELOAD: state <= FINISH;  // Merged word written here
				FINISH: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			heldOp <= op;
			heldFault <= fault;
		end
	end

	// Live request in IDLE, held one afterwards
	assign ramAddress = (state == IDLE) ? op.address[MMIO_BIT-1:2] : heldOp.address[MMIO_BIT-1:2];

	// sw on the accept edge, sb/sh one edge later
	assign writeEnable = (accept && op.write && op.funct3 == 3'b010 && !fault) || state == PRELOAD;

	always_comb
	begin
		if (state == PRELOAD)
		begin
			if (heldOp.funct3[0])
				ramDataIn = withHalfwordAtOffset(ramDataOut, swapBytes16(heldOp.data[15:0]),
					heldOp.address[1:0]);  // sh
			else
				ramDataIn = withByteAtOffset(ramDataOut, heldOp.data[7:0], heldOp.address[1:0]);
		end
		else
			ramDataIn = swapBytes32(op.data);  // sw
	end

	// Lane pick and extension of the word read back
	assign byteLane = byteAtOffset(ramDataOut, heldOp.address[1:0]);
	assign halfLane = swapBytes16(halfwordAtOffset(ramDataOut, heldOp.address[1:0]));

	always_comb
	begin
		case (heldOp.funct3)
			3'b000: loadValue = {{24{byteLane[7]}}, byteLane};  // lb
			3'b001: loadValue = {{16{halfLane[15]}}, halfLane};  // lh
			3'b100: loadValue = {24'b0, byteLane};  // lbu
			3'b101: loadValue = {16'b0, halfLane};  // lhu
			default: loadValue = swapBytes32(ramDataOut);  // lw
		endcase
	end

	assign response.data = (heldOp.write || heldFault) ? '0 : loadValue;
	assign response.fault = heldFault;

	assign instruction = swapBytes32(rawInstruction);

	InferredRAM inferredRam
	(
		.clock,
		.writeEnable,
		.writeAddress(ramAddress),
		.readAddressA(ramAddress),
		.readAddressB(fetchAddress),
		.dataIn(ramDataIn),
		.dataOutA(ramDataOut),
		.dataOutB(rawInstruction)
	);

	// Accepted op answers next cycle unless it is preloading
	assert property (@(posedge clock) disable iff (reset) accept |=> opDone || state == PRELOAD);

	// A faulting request must leave memory alone for its whole lifetime
	assert property (@(posedge clock) disable iff (reset)
		((accept && fault) || (state != IDLE && heldFault)) |-> !writeEnable);
endmodule: RAMWrapper

`default_nettype wire

// ==== logic/DataPortArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memory_config.svh"

module DataPortArbiter
(
	input logic clock,
	input logic reset,
	input logic [`MEM_PEER_COUNT-1:0] reqValid,
	input MemoryTypes::MemRequest_t requests [`MEM_PEER_COUNT],
	output logic [`MEM_PEER_COUNT-1:0] reqReady,
	output logic [`MEM_PEER_COUNT-1:0] respValid,
	output MemoryTypes::MemResponse_t responses [`MEM_PEER_COUNT],
	output logic opValid,
	output MemoryTypes::MemRequest_t op,
	input logic opReady,
	input logic opDone,
	input MemoryTypes::MemResponse_t response
);
	localparam int PEERS = `MEM_PEER_COUNT;
	localparam int INDEX_WIDTH = (PEERS > 1) ? $clog2(PEERS) : 1;

	logic [INDEX_WIDTH-1:0] lastGrant;  // Also the owner while busy
	logic [INDEX_WIDTH-1:0] winner;
	logic anyValid;
	logic busy;  // Operation outstanding in the wrapper
	logic grant;

	// Scan from furthest to nearest after lastGrant, nearest wins
	always_comb
	begin
		winner = lastGrant;
		anyValid = 1'b0;
		for (int i = PEERS; i >= 1; i--)
		begin
			if (reqValid[(int'(lastGrant) + i) % PEERS])
			begin
				winner = INDEX_WIDTH'((int'(lastGrant) + i) % PEERS);
				anyValid = 1'b1;
			end
		end
	end

	assign opValid = !busy && anyValid;
	assign op = requests[winner];
	assign grant = opValid && opReady;

	always_comb
	begin
		reqReady = '0;
		reqReady[winner] = grant;  // Only the winner sees ready
	end

	// Response goes back to the owner alone
	always_comb
	begin
		for (int p = 0; p < PEERS; p++)
		begin
			respValid[p] = opDone && lastGrant == INDEX_WIDTH'(p);
			responses[p] = response;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			lastGrant <= INDEX_WIDTH'(PEERS - 1);  // Peer 0 first after reset
		end
		else if (grant)
		begin
			busy <= 1'b1;
			lastGrant <= winner;
		end
		else if (opDone)
			busy <= 1'b0;
	end

	// When every peer asks, the last winner waits its turn
	assert property (@(posedge clock) disable iff (reset)
		(grant && &reqValid) |-> !reqReady[lastGrant]);

	// Wrapper completion only for an operation this arbiter granted
	assert property (@(posedge clock) disable iff (reset) |respValid |-> busy);
endmodule: DataPortArbiter

`default_nettype wire

// ==== logic/AxiLiteMemorySlave.sv ====
`timescale 1ns/1ps
`default_nettype none

module AxiLiteMemorySlave
(
	input logic clock,
	input logic reset,
	input logic awvalid,
	output logic awready,
	input MemoryTypes::ByteAddress_t awaddr,
	input logic wvalid,
	output logic wready,
	input MemoryTypes::Word_t wdata,
	input logic [3:0] wstrb,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input MemoryTypes::ByteAddress_t araddr,
	output logic rvalid,
	input logic rready,
	output MemoryTypes::Word_t rdata,
	output logic [1:0] rresp,
	output logic reqValid,
	output MemoryTypes::MemRequest_t request,
	input logic reqReady,
	input logic respValid,
	input MemoryTypes::MemResponse_t response
);
	import MemoryTypes::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam Funct3_t FUNCT3_WORD = 3'b010;  // Host only moves whole words

	AxiSlaveState_t state;
	logic isWrite;
	logic errorFlag;  // SLVERR on the way out
	ByteAddress_t heldAddress;
	Word_t heldData;  // Write data, then read data

	// Reads win when both arrive, writes need AW and W together
	assign arready = state == AXI_IDLE && arvalid;
	assign awready = state == AXI_IDLE && !arvalid && awvalid && wvalid;
	assign wready = awready;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= AXI_IDLE;
			isWrite <= 1'b0;
		end
		else
		begin
			case (state)
				AXI_IDLE:
					if (arready)
					begin
						state <= AXI_ISSUE;
						isWrite <= 1'b0;
					end
					else if (awready)
					begin
						state <= (&wstrb) ? AXI_ISSUE : AXI_RESPOND;  // Partial strobe refused
						isWrite <= 1'b1;
					end
				AXI_ISSUE: if (reqReady) state <= AXI_WAIT;
				AXI_WAIT: if (respValid) state <= AXI_RESPOND;
				AXI_RESPOND: if (isWrite ? bready : rready) state <= AXI_IDLE;
				default: state <= AXI_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (arready)
		begin
			heldAddress <= araddr;
			errorFlag <= 1'b0;
		end
		else if (awready)
		begin
			heldAddress <= awaddr;
			heldData <= wdata;
			errorFlag <= !(&wstrb);
		end
		else if (state == AXI_WAIT && respValid)
		begin
			errorFlag <= response.fault;  // MMIO address lands here
			if (!isWrite)
				heldData <= response.data;
		end
	end

	assign reqValid = state == AXI_ISSUE;
	assign request = '{write: isWrite, funct3: FUNCT3_WORD, address: heldAddress, data: heldData};

	assign bvalid = state == AXI_RESPOND && isWrite;
	assign rvalid = state == AXI_RESPOND && !isWrite;
	assign bresp = errorFlag ? RESP_SLVERR : RESP_OKAY;
	assign rresp = errorFlag ? RESP_SLVERR : RESP_OKAY;
	assign rdata = heldData;

	// Arbiter answers only while a request is outstanding
	assert property (@(posedge clock) disable iff (reset) respValid |-> state == AXI_WAIT);
endmodule: AxiLiteMemorySlave

`default_nettype wire

// ==== logic/MemorySubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memory_config.svh"

module MemorySubsystem
(
	input logic clock,
	input logic reset,
	input logic coreReqValid,
	input MemoryTypes::MemRequest_t coreRequest,
	output logic coreReqReady,
	output logic coreRespValid,
	output MemoryTypes::MemResponse_t coreResponse,
	input logic awvalid,
	output logic awready,
	input MemoryTypes::ByteAddress_t awaddr,
	input logic wvalid,
	output logic wready,
	input MemoryTypes::Word_t wdata,
	input logic [3:0] wstrb,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input MemoryTypes::ByteAddress_t araddr,
	output logic rvalid,
	input logic rready,
	output MemoryTypes::Word_t rdata,
	output logic [1:0] rresp,
	input MemoryTypes::WordAddress_t fetchAddress,
	output MemoryTypes::Word_t instruction
);
	import MemoryTypes::*;

	// Host side peer
	logic axiReqValid;
	logic axiReqReady;
	logic axiRespValid;
	MemRequest_t axiRequest;
	MemResponse_t axiResponse;

	// Peer 0 core, peer 1 host
	logic [`MEM_PEER_COUNT-1:0] peerReqValid;
	logic [`MEM_PEER_COUNT-1:0] peerReqReady;
	logic [`MEM_PEER_COUNT-1:0] peerRespValid;
	MemRequest_t peerRequests [`MEM_PEER_COUNT];
	MemResponse_t peerResponses [`MEM_PEER_COUNT];

	// Arbiter to wrapper
	logic opValid;
	logic opReady;
	logic opDone;
	MemRequest_t op;
	MemResponse_t opResponse;

	assign peerReqValid = {axiReqValid, coreReqValid};
	assign peerRequests = '{coreRequest, axiRequest};
	assign coreReqReady = peerReqReady[0];
	assign coreRespValid = peerRespValid[0];
	assign coreResponse = peerResponses[0];
	assign axiReqReady = peerReqReady[1];
	assign axiRespValid = peerRespValid[1];
	assign axiResponse = peerResponses[1];

	AxiLiteMemorySlave axiSlave
	(
		.clock, .reset,
		.awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
		.reqValid(axiReqValid), .request(axiRequest), .reqReady(axiReqReady),
		.respValid(axiRespValid), .response(axiResponse)
	);

	DataPortArbiter arbiter
	(
		.clock, .reset,
		.reqValid(peerReqValid), .requests(peerRequests), .reqReady(peerReqReady),
		.respValid(peerRespValid), .responses(peerResponses),
		.opValid, .op, .opReady, .opDone, .response(opResponse)
	);

	RAMWrapper ramWrapper
	(
		.clock, .reset,
		.opValid, .op, .opReady, .opDone, .response(opResponse),
		.fetchAddress, .instruction  // Port B straight through
	);
endmodule: MemorySubsystem

`default_nettype wire

// ==== bench/MemorySubsystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module MemorySubsystemTb;
	import MemoryTypes::*;

	// One parsed row of the test file
	typedef struct packed
	{
		logic [31:0] port;  // 0 core, 1 host
		logic [31:0] funct3;  // Strobe on host writes
		logic [31:0] address;
		logic [31:0] data;
		logic [31:0] expected;
	} TestLine_t;

	logic clock;
	logic reset;
	logic coreReqValid;
	MemRequest_t coreRequest;
	logic coreReqReady;
	logic coreRespValid;
	MemResponse_t coreResponse;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	ByteAddress_t awaddr, araddr;
	Word_t wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;
	WordAddress_t fetchAddress;
	Word_t instruction;

	string testOps[$];
	TestLine_t testLines[$];
	int testLineNumbers[$];
	int currentLine = 0;  // File line under test, for messages
	int checkCount = 0;
	int mismatchCount = 0;
	int otherErrors = 0;
	int cycleCount = 0;
	int cycleLimit = 100;  // Replaced once the file is read

	MemorySubsystem i_dut
	(
		.clock, .reset,
		.coreReqValid, .coreRequest, .coreReqReady, .coreRespValid, .coreResponse,
		.awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
		.fetchAddress, .instruction
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;  // 100 MHz
	end

	// Run limit, 40 cycles per test line
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, stuck at test file line %0d", cycleCount,
				currentLine);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			mismatchCount++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h (test file line %0d)", name,
				actual, expected, currentLine);
		end
	endtask

	function automatic MemRequest_t makeRequest(input logic isWrite, input TestLine_t t,
		input logic [31:0] value);
		MemRequest_t req;
		req.write = isWrite;
		req.funct3 = Funct3_t'(t.funct3);
		req.address = ByteAddress_t'(t.address);
		req.data = value;
		return req;
	endfunction

	// Core port, hold valid until ready then wait for the response pulse
	task automatic coreAccess(input MemRequest_t req, output MemResponse_t resp);
		@(posedge clock);
		coreReqValid <= 1'b1;
		coreRequest <= req;
		@(negedge clock);
		while (!coreReqReady)
			@(negedge clock);
		@(posedge clock);  // Accept edge
		coreReqValid <= 1'b0;
		@(negedge clock);
		while (!coreRespValid)
			@(negedge clock);
		resp = coreResponse;
	endtask

	// Random back-pressure before taking B or R
	task automatic takeAxiResponse(input logic isWrite);
		int delay;
		delay = int'($urandom % 4);
		repeat (delay)
			@(posedge clock);
		@(posedge clock);
		if (isWrite)
			bready <= 1'b1;
		else
			rready <= 1'b1;
		@(posedge clock);  // Handshake edge
		bready <= 1'b0;
		rready <= 1'b0;
	endtask

	task automatic axiWrite(input logic [31:0] addr, input Word_t value, input logic [3:0] strobe,
		output logic [1:0] resp);
		@(posedge clock);
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		awaddr <= ByteAddress_t'(addr);
		wdata <= value;
		wstrb <= strobe;
		@(negedge clock);
		while (!awready)
			@(negedge clock);
		checkValue("wready", 32'(wready), 32'h1);  // W taken with AW
		@(posedge clock);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(negedge clock);
		while (!bvalid)
			@(negedge clock);
		resp = bresp;
		takeAxiResponse(1'b1);
	endtask

	task automatic axiRead(input logic [31:0] addr, output Word_t value, output logic [1:0] resp);
		@(posedge clock);
		arvalid <= 1'b1;
		araddr <= ByteAddress_t'(addr);
		@(negedge clock);
		while (!arready)
			@(negedge clock);
		@(posedge clock);
		arvalid <= 1'b0;
		@(negedge clock);
		while (!rvalid)
			@(negedge clock);
		value = rdata;
		resp = rresp;
		takeAxiResponse(1'b0);
	endtask

	// Port B, word is out one edge after the address
	task automatic fetchWord(input logic [31:0] addr, output Word_t word);
		@(posedge clock);
		fetchAddress <= WordAddress_t'(addr >> 2);
		@(posedge clock);
		@(negedge clock);
		word = instruction;
	endtask

	initial
	begin
		int fd;
		int fields;
		int fileLine;
		string textLine;
		string opName;
		logic [31:0] port, funct3, address, data, expected;
		TestLine_t t;
		MemResponse_t coreResp;
		Word_t axiData;
		Word_t fetched;
		logic [1:0] axiResp;

		void'($urandom(24206));
		reset = 1'b1;
		coreReqValid = 1'b0;
		coreRequest = '0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		fetchAddress = '0;

		fd = $fopen("bench/memory_tests.txt", "r");
		if (fd == 0)
		begin
			otherErrors++;
			$display("Could not open the test file bench/memory_tests.txt");
		end
		else
		begin
			fileLine = 0;
			while ($fgets(textLine, fd) != 0)
			begin
				fileLine++;
				if (textLine.len() < 2 || textLine.substr(0, 0) == "#")
					continue;  // Blank or comment
				fields = $sscanf(textLine, "%s %h %h %h %h %h", opName, port, funct3, address,
					data, expected);
				if (fields != 6)
				begin
					otherErrors++;
					$display("Test file line %0d could not be parsed", fileLine);
				end
				else
				begin
					t = '{port, funct3, address, data, expected};
					testOps.push_back(opName);
					testLines.push_back(t);
					testLineNumbers.push_back(fileLine);
				end
			end
			$fclose(fd);
		end
		if (testOps.size() == 0)
		begin
			otherErrors++;
			$display("No tests were found in the test file");
		end
		cycleLimit = 40 * testOps.size() + 20;  // Reset and margin on top

		repeat (8)
			@(posedge clock);
		reset <= 1'b0;

		for (int i = 0; i < testOps.size(); i++)
		begin
			t = testLines[i];
			currentLine = testLineNumbers[i];
			case (testOps[i])
				"st", "stx":
					if (t.port == 0)
					begin
						coreAccess(makeRequest(1'b1, t, t.data), coreResp);
						checkValue("coreResponse.fault", 32'(coreResp.fault),
							32'(testOps[i] == "stx"));
					end
					else
					begin
						axiWrite(t.address, t.data, t.funct3[3:0], axiResp);
						checkValue("bresp", 32'(axiResp), (testOps[i] == "stx") ? 32'h2 : 32'h0);
					end
				"ld", "ldx":
					if (t.port == 0)
					begin
						coreAccess(makeRequest(1'b0, t, '0), coreResp);
						checkValue("coreResponse.fault", 32'(coreResp.fault),
							32'(testOps[i] == "ldx"));
						checkValue("coreResponse.data", coreResp.data, t.expected);
					end
					else
					begin
						axiRead(t.address, axiData, axiResp);
						checkValue("rresp", 32'(axiResp), (testOps[i] == "ldx") ? 32'h2 : 32'h0);
						checkValue("rdata", axiData, t.expected);
					end
				"fe":
				begin
					fetchWord(t.address, fetched);
					checkValue("instruction", fetched, t.expected);
				end
				"par":
				begin
					// Core lags one cycle so both meet at the arbiter
					fork
						begin
							@(posedge clock);
							coreAccess(makeRequest(1'b1, t, t.data), coreResp);
						end
						axiWrite(t.address + 4, t.expected, 4'hf, axiResp);
					join
					checkValue("coreResponse.fault", 32'(coreResp.fault), 32'h0);
					checkValue("bresp", 32'(axiResp), 32'h0);
				end
				"parl":
				begin
					fork
						begin
							@(posedge clock);
							coreAccess(makeRequest(1'b0, t, '0), coreResp);
						end
						axiRead(t.address + 4, axiData, axiResp);
					join
					checkValue("coreResponse.data", coreResp.data, t.data);
					checkValue("rdata", axiData, t.expected);
					checkValue("rresp", 32'(axiResp), 32'h0);
				end
				default:
				begin
					otherErrors++;
					$display("Unknown operation %s on test file line %0d", testOps[i], currentLine);
				end
			endcase
		end

		$display("Summary: %0d checks, %0d mismatches, %0d other errors", checkCount,
			mismatchCount, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end
endmodule: MemorySubsystemTb

`default_nettype wire

// ==== bench/memory_tests.txt ====
# op port funct3 address data expected, all hex, port 0 core and 1 host
# host writes put the strobe in funct3; par/parl pair core at address with host at address+4
st 0 2 000 12345678 0
ld 0 2 000 0 12345678
st 0 0 001 000000ab 0
ld 0 2 000 0 1234ab78
st 0 1 002 0000beef 0
ld 0 2 000 0 beefab78
ld 0 0 003 0 ffffffbe
ld 0 4 003 0 000000be
ld 0 1 002 0 ffffbeef
ld 0 5 002 0 0000beef
ld 0 0 000 0 00000078
ld 0 1 000 0 ffffab78
st 1 f 010 cafef00d 0
ld 0 2 010 0 cafef00d
st 0 2 014 0badc0de 0
ld 1 0 014 0 0badc0de
fe 0 0 010 0 cafef00d
fe 0 0 000 0 beefab78
ldx 0 1 001 0 0
ldx 0 2 002 0 0
ldx 0 2 1000 0 0
ldx 0 3 000 0 0
stx 0 2 1010 11111111 0
stx 0 2 012 22222222 0
ld 0 2 010 0 cafef00d
stx 1 f 1014 33333333 0
stx 1 3 014 44444444 0
ldx 1 0 1014 0 0
ld 0 2 014 0 0badc0de
par 0 2 020 13579bdf 2468ace0
parl 0 2 020 13579bdf 2468ace0
par 0 2 030 0f0f0f0f f0f0f0f0
parl 0 2 030 0f0f0f0f f0f0f0f0

// ==== compile.f ====
+incdir+include
logic/MemoryTypes.sv
logic/InferredRAM.sv
logic/RAMWrapper.sv
logic/DataPortArbiter.sv
logic/AxiLiteMemorySlave.sv
logic/MemorySubsystem.sv
bench/MemorySubsystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module MemorySubsystemTb \
	-Mdir obj_dir \
	-o MemorySubsystemTb

./obj_dir/MemorySubsystemTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
	exit 1
fi
exit 0
